// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing --top-module axil_iob_tb \
		-f all.f -o axil_iob_sim
	./obj_dir/axil_iob_sim 2>&1 | tee sim.log
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+source
source/axil_pkg.sv
source/iob_pkg.sv
source/axil_req_capture.sv
source/axil2iob.sv
source/iob_reg_bank.sv
source/axil_iob_top.sv
verif/axil_iob_asserts.sv
verif/axil_iob_tb.sv

// File: source/axil2iob.sv
`timescale 1ns/10ps

`include "axil_iob_defs.svh"

module axil2iob (
   input  logic              clk,
   input  logic              rst_n,
   // transaction from stage 1
   input  axil_pkg::txn_t    txn,
   output logic              txn_ready,
   // IOb master side
   output iob_pkg::iob_req_t req,
   input  iob_pkg::iob_rsp_t rsp,
   // AXI-Lite responses
   output axil_pkg::b_t      b,
   output axil_pkg::r_t      r,
   input  logic              bready,
   input  logic              rready
);

   logic req_vld;
   logic is_wr;
   logic rd_wait;
   logic b_vld;
   logic r_vld;

   iob_pkg::iob_addr_t req_addr;
   iob_pkg::iob_data_t req_wdata;
   iob_pkg::iob_strb_t req_wstrb;

   axil_pkg::resp_t b_resp;
   axil_pkg::data_t r_data;
   axil_pkg::resp_t r_resp;
   axil_pkg::resp_t rsp_code;

   logic txn_fire;
   logic req_acc;
   logic rd_done;

   // one transaction at a time
   assign txn_ready = ~(req_vld | rd_wait | b_vld | r_vld);
   assign txn_fire  = txn.valid & txn_ready;
   assign req_acc   = req_vld & rsp.ready;
   assign rd_done   = rd_wait & rsp.rvalid;
   assign rsp_code  = rsp.err ? `RESP_SLVERR : `RESP_OKAY;

   always_comb begin
      req.valid = req_vld;
      req.addr  = req_addr;
      req.wdata = req_wdata;
      req.wstrb = req_wstrb;
      b.valid   = b_vld;
      b.resp    = b_resp;
      r.valid   = r_vld;
      r.data    = r_data;
      r.resp    = r_resp;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_vld <= 1'b0;
         is_wr   <= 1'b0;
         rd_wait <= 1'b0;
         b_vld   <= 1'b0;
         r_vld   <= 1'b0;
      end else begin
         if (txn_fire) begin
            req_vld <= 1'b1;
            is_wr   <= txn.write;
         end else if (req_acc) begin
            req_vld <= 1'b0;
         end
         // reads wait one more cycle for rvalid
         if (req_acc && !is_wr) begin
            rd_wait <= 1'b1;
         end else if (rd_done) begin
            rd_wait <= 1'b0;
         end
         if (req_acc && is_wr) begin
            b_vld <= 1'b1;
         end else if (b_vld && bready) begin
            b_vld <= 1'b0;
         end
         if (rd_done) begin
            r_vld <= 1'b1;
         end else if (r_vld && rready) begin
            r_vld <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (txn_fire) begin
         req_addr  <= txn.addr;
         req_wdata <= txn.data;
         // zero strobes mark a read on IOb
         req_wstrb <= txn.write ? txn.strb : '0;
      end
      if (req_acc && is_wr) begin
         b_resp <= rsp_code;
      end
      if (rd_done) begin
         r_data <= rsp.rdata;
         r_resp <= rsp_code;
      end
   end

endmodule

// File: source/axil_iob_defs.svh
`ifndef AXIL_IOB_DEFS_SVH
`define AXIL_IOB_DEFS_SVH

// byte address width, shared by AXI-Lite and IOb
`define ADDR_W 32

// data word width
`define DATA_W 32

// words in the register bank
`define NUM_REGS 16

// AXI response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

// File: source/axil_iob_top.sv
`timescale 1ns/10ps

module axil_iob_top (
   input  logic          clk,
   input  logic          rst_n,
   // AXI-Lite slave port
   input  axil_pkg::aw_t aw,
   input  axil_pkg::w_t  w,
   input  axil_pkg::ar_t ar,
   input  logic          bready,
   input  logic          rready,
   output logic          awready,
   output logic          wready,
   output logic          arready,
   output axil_pkg::b_t  b,
   output axil_pkg::r_t  r
);

   axil_pkg::txn_t    txn;
   logic              txn_ready;
   iob_pkg::iob_req_t req;
   iob_pkg::iob_rsp_t rsp;

   // stage 1, channel capture
   axil_req_capture axil_req_capture_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .aw        (aw),
      .w         (w),
      .ar        (ar),
      .awready   (awready),
      .wready    (wready),
      .arready   (arready),
      .txn       (txn),
      .txn_ready (txn_ready)
   );

   // stage 2, IOb request and AXI response
   axil2iob axil2iob_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .txn       (txn),
      .txn_ready (txn_ready),
      .req       (req),
      .rsp       (rsp),
      .b         (b),
      .r         (r),
      .bready    (bready),
      .rready    (rready)
   );

   // stage 3, register bank
   iob_reg_bank iob_reg_bank_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req),
      .rsp   (rsp)
   );

endmodule

// File: source/axil_pkg.sv
`include "axil_iob_defs.svh"

package axil_pkg;

   typedef logic [`ADDR_W-1:0]   addr_t;
   typedef logic [`DATA_W-1:0]   data_t;
   typedef logic [`DATA_W/8-1:0] strb_t;
   typedef logic [1:0]           resp_t;

   // write address channel
   typedef struct packed {
      logic  valid;
      addr_t addr;
   } aw_t;

   // read address channel
   typedef struct packed {
      logic  valid;
      addr_t addr;
   } ar_t;

   // write data channel
   typedef struct packed {
      logic  valid;
      data_t data;
      strb_t strb;
   } w_t;

   // write response
   typedef struct packed {
      logic  valid;
      resp_t resp;
   } b_t;

   // read data and response
   typedef struct packed {
      logic  valid;
      data_t data;
      resp_t resp;
   } r_t;

   // one captured transaction, read or write
   typedef struct packed {
      logic  valid;
      logic  write;
      addr_t addr;
      data_t data;
      strb_t strb;
   } txn_t;

endpackage

// File: source/axil_req_capture.sv
`timescale 1ns/10ps

module axil_req_capture (
   input  logic           clk,
   input  logic           rst_n,
   // AXI-Lite request channels
   input  axil_pkg::aw_t  aw,
   input  axil_pkg::w_t   w,
   input  axil_pkg::ar_t  ar,
   output logic           awready,
   output logic           wready,
   output logic           arready,
   // captured transaction to stage 2
   output axil_pkg::txn_t txn,
   input  logic           txn_ready
);

   // holding register flags
   logic aw_full;
   logic w_full;
   logic ar_full;

   // set when the last served transaction was a read
   logic last_rd;

   axil_pkg::addr_t aw_addr;
   axil_pkg::data_t w_data;
   axil_pkg::strb_t w_strb;
   axil_pkg::addr_t ar_addr;

   logic aw_fire;
   logic w_fire;
   logic ar_fire;
   logic wr_ok;
   logic rd_ok;
   logic pick_rd;
   logic txn_fire;

   // a channel is ready while its slot is empty
   assign awready = ~aw_full;
   assign wready  = ~w_full;
   assign arready = ~ar_full;

   assign aw_fire = aw.valid & awready;
   assign w_fire  = w.valid & wready;
   assign ar_fire = ar.valid & arready;

   // write needs both halves
   assign wr_ok = aw_full & w_full;
   assign rd_ok = ar_full;

   // read goes when alone, or when the write had the last turn
   assign pick_rd  = rd_ok & (~wr_ok | ~last_rd);
   assign txn_fire = txn.valid & txn_ready;

   always_comb begin
      txn.valid = wr_ok | rd_ok;
      txn.write = ~pick_rd;
      txn.addr  = pick_rd ? ar_addr : aw_addr;
      txn.data  = w_data;
      txn.strb  = w_strb;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         aw_full <= 1'b0;
         w_full  <= 1'b0;
         ar_full <= 1'b0;
         last_rd <= 1'b0;
      end else begin
         // fill and drain never hit the same slot in one cycle
         if (aw_fire) begin
            aw_full <= 1'b1;
         end else if (txn_fire && !pick_rd) begin
            aw_full <= 1'b0;
         end
         if (w_fire) begin
            w_full <= 1'b1;
         end else if (txn_fire && !pick_rd) begin
            w_full <= 1'b0;
         end
         if (ar_fire) begin
            ar_full <= 1'b1;
         end else if (txn_fire && pick_rd) begin
            ar_full <= 1'b0;
         end
         if (txn_fire) begin
            last_rd <= pick_rd;
         end
      end
   end

   // channel payloads
   always_ff @(posedge clk) begin
      if (aw_fire) begin
         aw_addr <= aw.addr;
      end
      if (w_fire) begin
         w_data <= w.data;
         w_strb <= w.strb;
      end
      if (ar_fire) begin
         ar_addr <= ar.addr;
      end
   end

endmodule

// File: source/iob_pkg.sv
`include "axil_iob_defs.svh"

package iob_pkg;

   typedef logic [`ADDR_W-1:0]   iob_addr_t;
   typedef logic [`DATA_W-1:0]   iob_data_t;
   typedef logic [`DATA_W/8-1:0] iob_strb_t;

   // native request, zero wstrb reads
   typedef struct packed {
      logic      valid;
      iob_addr_t addr;
      iob_data_t wdata;
      iob_strb_t wstrb;
   } iob_req_t;

   // native response
   // err comes with rvalid on reads, with the accept on writes
   typedef struct packed {
      logic      ready;
      logic      rvalid;
      iob_data_t rdata;
      logic      err;
   } iob_rsp_t;

endpackage

// File: source/iob_reg_bank.sv
`timescale 1ns/10ps

`include "axil_iob_defs.svh"

module iob_reg_bank (
   input  logic              clk,
   input  logic              rst_n,
   input  iob_pkg::iob_req_t req,
   output iob_pkg::iob_rsp_t rsp
);

   localparam int IDX_W = $clog2(`NUM_REGS);
   localparam logic [`ADDR_W-3:0] NUM_WORDS = (`ADDR_W-2)'(`NUM_REGS);

   iob_pkg::iob_data_t mem [`NUM_REGS];

   // word address, byte offset dropped
   logic [`ADDR_W-3:0] word_addr;
   logic [IDX_W-1:0]   idx;
   logic               in_range;
   logic               wr_en;
   logic               rd_en;

   logic               rd_vld_q;
   logic               rd_err_q;
   iob_pkg::iob_data_t rdata_q;

   assign word_addr = req.addr[`ADDR_W-1:2];
   assign idx       = word_addr[IDX_W-1:0];
   assign in_range  = word_addr < NUM_WORDS;

   assign wr_en = req.valid & (|req.wstrb);
   assign rd_en = req.valid & ~(|req.wstrb);

   always_comb begin
      rsp.ready  = 1'b1;
      rsp.rvalid = rd_vld_q;
      rsp.rdata  = rdata_q;
      // read error follows rvalid, write error shows at accept
      rsp.err    = rd_vld_q ? rd_err_q : (req.valid & ~in_range);
   end

   // out of range writes are dropped
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_en && in_range) begin
         for (int lane = 0; lane < `DATA_W/8; lane++) begin
            if (req.wstrb[lane]) begin
               mem[idx][8*lane +: 8] <= req.wdata[8*lane +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_vld_q <= 1'b0;
      end else begin
         rd_vld_q <= rd_en;
      end
   end

   // read data one cycle after the request
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rdata_q  <= in_range ? mem[idx] : '0;
         rd_err_q <= ~in_range;
      end
   end

endmodule

// File: verif/axil_iob_asserts.sv
`timescale 1ns/10ps

module axil_iob_asserts (
   input logic          clk,
   input logic          rst_n,
   input axil_pkg::aw_t aw,
   input axil_pkg::w_t  w,
   input axil_pkg::ar_t ar,
   input logic          bready,
   input logic          rready,
   input logic          awready,
   input logic          wready,
   input logic          arready,
   input axil_pkg::b_t  b,
   input axil_pkg::r_t  r
);

   logic       aw_hs;
   logic       w_hs;
   logic       ar_hs;
   logic       b_hs;
   logic       r_hs;
   logic       wr_event;
   logic       aw_pend;
   logic       w_pend;
   logic [7:0] open_cnt;
   logic       b_watch;
   logic       r_watch;
   logic [7:0] b_age;
   logic [7:0] r_age;
   logic       no_bp;

   // failed assertion count
   int         fail_count = 0;

   assign aw_hs = aw.valid & awready;
   assign w_hs  = w.valid & wready;
   assign ar_hs = ar.valid & arready;
   assign b_hs  = b.valid & bready;
   assign r_hs  = r.valid & rready;
   assign no_bp = bready & rready;

   // both write halves done, the later one in this cycle
   assign wr_event = (aw_hs | aw_pend) & (w_hs | w_pend) & (aw_hs | w_hs);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         aw_pend  <= 1'b0;
         w_pend   <= 1'b0;
         open_cnt <= '0;
         b_watch  <= 1'b0;
         r_watch  <= 1'b0;
         b_age    <= '0;
         r_age    <= '0;
      end else begin
         if (wr_event) begin
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
         end else begin
            if (aw_hs) aw_pend <= 1'b1;
            if (w_hs) w_pend <= 1'b1;
         end
         open_cnt <= open_cnt + 8'(wr_event) + 8'(ar_hs) - 8'(b_hs) - 8'(r_hs);
         // latency watch only for a lone transaction without back-pressure
         if (wr_event && open_cnt == 0 && !ar_hs && no_bp) begin
            b_watch <= 1'b1;
            b_age   <= 8'd1;
         end else if (b.valid || !no_bp) begin
            b_watch <= 1'b0;
         end else if (b_watch) begin
            b_age <= b_age + 8'd1;
         end
         if (ar_hs && open_cnt == 0 && !wr_event && no_bp) begin
            r_watch <= 1'b1;
            r_age   <= 8'd1;
         end else if (r.valid || !no_bp) begin
            r_watch <= 1'b0;
         end else if (r_watch) begin
            r_age <= r_age + 8'd1;
         end
      end
   end

   a_reset_idle: assert property (@(posedge clk)
      $rose(rst_n) |-> (awready && wready && arready && !b.valid && !r.valid))
      else begin
         fail_count++;
         $error("ready or valid outputs not idle after reset");
      end

   a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (b.valid && !bready) |=> (b.valid && $stable(b.resp)))
      else begin
         fail_count++;
         $error("write response dropped or changed before bready");
      end

   a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (r.valid && !rready) |=> (r.valid && $stable(r.data) && $stable(r.resp)))
      else begin
         fail_count++;
         $error("read response dropped or changed before rready");
      end

   a_b_latency: assert property (@(posedge clk) disable iff (!rst_n)
      b_watch |-> (b_age <= 8'd8))
      else begin
         fail_count++;
         $error("write response later than 8 cycles");
      end

   a_r_latency: assert property (@(posedge clk) disable iff (!rst_n)
      r_watch |-> (r_age <= 8'd8))
      else begin
         fail_count++;
         $error("read response later than 8 cycles");
      end

endmodule

// File: verif/axil_iob_tb.sv
`timescale 1ns/10ps

`include "axil_iob_defs.svh"

module axil_iob_tb;

   localparam int TXN_COUNT = 96;
   localparam int CYCLE_LIMIT = 20 * TXN_COUNT + 200;

   logic          clk;
   logic          rst_n;
   axil_pkg::aw_t aw;
   axil_pkg::w_t  w;
   axil_pkg::ar_t ar;
   logic          bready;
   logic          rready;
   logic          awready;
   logic          wready;
   logic          arready;
   axil_pkg::b_t  b;
   axil_pkg::r_t  r;

   logic [31:0]     rng_state;
   axil_pkg::data_t ref_mem [`NUM_REGS];
   axil_pkg::resp_t exp_bresp [$];
   axil_pkg::data_t exp_rdata [$];
   axil_pkg::resp_t exp_rresp [$];
   // service order, 1 for a write
   logic            exp_kind [$];
   logic            held_aw;
   logic            held_w;
   logic            held_ar;
   logic            busy;
   logic            last_rd;
   logic            serve_wr;
   int              err_count;
   int              assert_fails;
   int              n_wr;
   int              n_rd;
   int              b_count;
   int              r_count;
   int              cycles;
   logic            bp_en;
   int              bp_len;
   int              i;
   int              k;
   axil_pkg::addr_t addr;
   axil_pkg::data_t data;
   axil_pkg::strb_t strb;

   axil_iob_top axil_iob_top_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .aw      (aw),
      .w       (w),
      .ar      (ar),
      .bready  (bready),
      .rready  (rready),
      .awready (awready),
      .wready  (wready),
      .arready (arready),
      .b       (b),
      .r       (r)
   );

   bind axil_iob_top axil_iob_asserts axil_iob_asserts_inst (.*);

   initial clk = 1'b0;
   always #2 clk = ~clk;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // byte lane merge of a write into the reference word
   function automatic axil_pkg::data_t merge_lanes(axil_pkg::data_t old_word,
                                                   axil_pkg::data_t new_word,
                                                   axil_pkg::strb_t lanes);
      axil_pkg::data_t res;
      res = old_word;
      for (int n = 0; n < `DATA_W/8; n++) begin
         if (lanes[n]) res[8*n +: 8] = new_word[8*n +: 8];
      end
      return res;
   endfunction

   function automatic axil_pkg::addr_t word_addr(int idx);
      return axil_pkg::addr_t'(idx << 2) | axil_pkg::addr_t'(next_rand() & 3);
   endfunction

   task automatic send_aw(input axil_pkg::addr_t a);
      logic done;
      @(posedge clk);
      #1;
      aw.valid = 1'b1;
      aw.addr  = a;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         done = awready;
         @(posedge clk);
         #1;
      end
      aw.valid = 1'b0;
   endtask

   task automatic send_w(input axil_pkg::data_t d, input axil_pkg::strb_t s);
      logic done;
      @(posedge clk);
      #1;
      w.valid = 1'b1;
      w.data  = d;
      w.strb  = s;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         done = wready;
         @(posedge clk);
         #1;
      end
      w.valid = 1'b0;
   endtask

   task automatic send_ar(input axil_pkg::addr_t a);
      logic done;
      @(posedge clk);
      #1;
      ar.valid = 1'b1;
      ar.addr  = a;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         done = arready;
         @(posedge clk);
         #1;
      end
      ar.valid = 1'b0;
   endtask

   // mode 0 AW first, 1 W first, 2 both together
   task automatic do_write(input axil_pkg::addr_t a, input axil_pkg::data_t d,
                           input axil_pkg::strb_t s, input int mode);
      logic ok;
      ok = a[`ADDR_W-1:2] < `NUM_REGS;
      if (ok) ref_mem[a[5:2]] = merge_lanes(ref_mem[a[5:2]], d, s);
      exp_bresp.push_back(ok ? `RESP_OKAY : `RESP_SLVERR);
      n_wr++;
      if (mode == 0) begin
         send_aw(a);
         send_w(d, s);
      end else if (mode == 1) begin
         send_w(d, s);
         send_aw(a);
      end else begin
         fork
            send_aw(a);
            send_w(d, s);
         join
      end
   endtask

   task automatic do_read(input axil_pkg::addr_t a);
      logic ok;
      ok = a[`ADDR_W-1:2] < `NUM_REGS;
      exp_rdata.push_back(ok ? ref_mem[a[5:2]] : '0);
      exp_rresp.push_back(ok ? `RESP_OKAY : `RESP_SLVERR);
      n_rd++;
      send_ar(a);
   endtask

   task automatic wait_idle();
      while (exp_bresp.size() != 0 || exp_rdata.size() != 0) @(posedge clk);
      @(posedge clk);
   endtask

   // responses are checked half a cycle before their transfer edge
   always @(negedge clk) begin
      if (rst_n && b.valid && bready) begin
         if (exp_bresp.size() == 0) begin
            err_count++;
            $display("write response arrived with none outstanding");
         end else begin
            b_count++;
            assert (b.resp == exp_bresp[0]) else begin
               err_count++;
               $display("Fail b.resp expected %h got %h", exp_bresp[0], b.resp);
            end
            void'(exp_bresp.pop_front());
         end
         assert (exp_kind.size() != 0 && exp_kind[0]) else begin
            err_count++;
            $display("write response came out of the predicted service order");
         end
         if (exp_kind.size() != 0) void'(exp_kind.pop_front());
      end
      if (rst_n && r.valid && rready) begin
         if (exp_rdata.size() == 0) begin
            err_count++;
            $display("read response arrived with none outstanding");
         end else begin
            r_count++;
            assert (r.data == exp_rdata[0]) else begin
               err_count++;
               $display("Fail r.data expected %h got %h", exp_rdata[0], r.data);
            end
            assert (r.resp == exp_rresp[0]) else begin
               err_count++;
               $display("Fail r.resp expected %h got %h", exp_rresp[0], r.resp);
            end
            void'(exp_rdata.pop_front());
            void'(exp_rresp.pop_front());
         end
         assert (exp_kind.size() != 0 && !exp_kind[0]) else begin
            err_count++;
            $display("read response came out of the predicted service order");
         end
         if (exp_kind.size() != 0) void'(exp_kind.pop_front());
      end
      // one transaction in flight, held read and write take turns
      if (rst_n) begin
         if (!busy && ((held_aw && held_w) || held_ar)) begin
            serve_wr = held_aw && held_w && (!held_ar || last_rd);
            exp_kind.push_back(serve_wr);
            last_rd = !serve_wr;
            busy = 1'b1;
            if (serve_wr) begin
               held_aw = 1'b0;
               held_w  = 1'b0;
            end else begin
               held_ar = 1'b0;
            end
         end
         if (aw.valid && awready) held_aw = 1'b1;
         if (w.valid && wready) held_w = 1'b1;
         if (ar.valid && arready) held_ar = 1'b1;
         if ((b.valid && bready) || (r.valid && rready)) busy = 1'b0;
      end
   end

   // random stretches of response back-pressure
   always @(posedge clk) begin
      #1;
      if (!bp_en) begin
         bready = 1'b1;
         rready = 1'b1;
         bp_len = 0;
      end else if (bp_len == 0) begin
         bready = 1'(next_rand() % 2);
         rready = 1'(next_rand() % 2);
         bp_len = 1 + next_rand() % 5;
      end else begin
         bp_len--;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles with responses still missing", cycles);
         $display("TB FAILED");
         $finish;
      end
   end

   initial begin
      rng_state = 32'h94e6;
      err_count = 0;
      n_wr = 0;
      n_rd = 0;
      b_count = 0;
      r_count = 0;
      cycles = 0;
      bp_en = 1'b0;
      bp_len = 0;
      held_aw = 1'b0;
      held_w = 1'b0;
      held_ar = 1'b0;
      busy = 1'b0;
      last_rd = 1'b0;
      serve_wr = 1'b0;
      aw = '0;
      w = '0;
      ar = '0;
      bready = 1'b1;
      rready = 1'b1;
      rst_n = 1'b0;
      for (i = 0; i < `NUM_REGS; i++) ref_mem[i] = '0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      repeat (2) @(posedge clk);

      // write then read back the same word
      for (i = 0; i < 8; i++) begin
         addr = word_addr(next_rand() % `NUM_REGS);
         data = next_rand();
         strb = axil_pkg::strb_t'(next_rand());
         if (strb == 0) strb = '1;
         do_write(addr, data, strb, 2);
         wait_idle();
         do_read(addr);
         wait_idle();
      end

      // AW alone first, W alone first, both together
      for (i = 0; i < 3; i++) begin
         for (k = 0; k < 3; k++) begin
            addr = word_addr(next_rand() % `NUM_REGS);
            do_write(addr, next_rand(), 4'hf, k);
            wait_idle();
            do_read(addr);
            wait_idle();
         end
      end

      // out of range write and read, then every valid word
      addr = 32'h40 + (next_rand() & 32'h0000_0fff);
      do_write(addr, next_rand(), 4'hf, 2);
      wait_idle();
      addr = 32'h40 + (next_rand() & 32'h0000_0fff);
      do_read(addr);
      wait_idle();
      for (i = 0; i < `NUM_REGS; i++) begin
         do_read(word_addr(i));
         wait_idle();
      end

      // response back-pressure
      bp_en = 1'b1;
      for (i = 0; i < 12; i++) begin
         addr = word_addr(next_rand() % `NUM_REGS);
         strb = axil_pkg::strb_t'(next_rand());
         if (strb == 0) strb = 4'h1;
         do_write(addr, next_rand(), strb, next_rand() % 3);
         wait_idle();
         do_read(addr);
         wait_idle();
      end
      bp_en = 1'b0;

      // writes to even words race reads of odd words
      for (i = 0; i < 10; i++) begin
         fork
            do_write(word_addr(2 * (next_rand() % 8)), next_rand(), 4'hf, next_rand() % 3);
            do_read(word_addr(2 * (next_rand() % 8) + 1));
         join
      end
      wait_idle();

      assert (b_count == n_wr) else begin
         err_count++;
         $display("Fail b count expected %h got %h", n_wr, b_count);
      end
      assert (r_count == n_rd) else begin
         err_count++;
         $display("Fail r count expected %h got %h", n_rd, r_count);
      end
      assert_fails = axil_iob_top_inst.axil_iob_asserts_inst.fail_count;
      $display("errors %0d, assertion failures %0d, writes %0d, reads %0d, b %0d, r %0d",
               err_count, assert_fails, n_wr, n_rd, b_count, r_count);
      if (err_count == 0 && assert_fails == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule
